// ==== Makefile ====
# Verilator build and run of the lockstep testbench

LOG := sim.log

sim:
	verilator --binary --timing -f sources.f --top-module tb_dcls -o tb_dcls
	./obj_dir/tb_dcls | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== design/dcls_pkg.sv ====
// Shared types for the dual-core lockstep supervisor.
// Every RTL module imports this package to get the bus widths,
// the AHB transfer codes and the request and response structs.

package dcls_pkg;

    // Lag of the trailing core behind the leading core, in cycles
    localparam int CORE_LAG = 1;

    typedef logic [31:0] addr_t;    // AHB address
    typedef logic [31:0] data_t;    // AHB read or write data word
    typedef logic [1:0]  htrans_t;  // AHB transfer type
    typedef logic [2:0]  hsize_t;   // AHB transfer size
    typedef logic [5:0]  parity_t;  // Request parity from the core
    typedef logic [2:0]  triple_t;  // Three redundant copies of one flag

    // Transfer type codes
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // One core's request on one bus, 76 bits
    typedef struct packed {
        htrans_t htrans;
        addr_t   haddr;
        logic    hwrite;
        hsize_t  hsize;
        parity_t hparity;
        data_t   hwdata;    // Data phase of the previous transfer
    } bus_req_t;

    // Response seen by one core on one bus, 34 bits
    typedef struct packed {
        logic  hready;
        logic  hresp;
        data_t hrdata;
    } bus_rsp_t;

endpackage

// ==== design/dcls_top.sv ====
// Top level of the dual-core lockstep supervisor.
// Sits between two RISC-V cores and their AHB-Lite instruction and data
// buses. The cores connect to the lead_* and trail_* ports, the buses to
// the voted response inputs and the ibus/dbus request outputs.

module dcls_top (
    input  logic               s_clk_i,
    input  logic               reset_i,

    // Instruction bus response, flags triplicated
    input  dcls_pkg::triple_t  i_hready_i,
    input  dcls_pkg::triple_t  i_hresp_i,
    input  dcls_pkg::data_t    i_hrdata_i,

    // Data bus response, flags triplicated
    input  dcls_pkg::triple_t  d_hready_i,
    input  dcls_pkg::triple_t  d_hresp_i,
    input  dcls_pkg::data_t    d_hrdata_i,

    input  logic               meip_i,
    input  logic               mtip_i,

    // Requests from both cores
    input  dcls_pkg::bus_req_t lead_ireq_i,
    input  dcls_pkg::bus_req_t trail_ireq_i,
    input  dcls_pkg::bus_req_t lead_dreq_i,
    input  dcls_pkg::bus_req_t trail_dreq_i,

    // Responses and side inputs to both cores
    output dcls_pkg::bus_rsp_t lead_irsp_o,
    output dcls_pkg::bus_rsp_t lead_drsp_o,
    output dcls_pkg::bus_rsp_t trail_irsp_o,
    output dcls_pkg::bus_rsp_t trail_drsp_o,
    output logic               trail_meip_o,
    output logic               trail_mtip_o,
    output logic               trail_reset_o,

    // External buses and the lockstep error
    output dcls_pkg::bus_req_t ibus_req_o,
    output dcls_pkg::bus_req_t dbus_req_o,
    output logic               unrec_err_o
);

    import dcls_pkg::*;

    // Aligned request pairs for the comparator
    bus_req_t ibus_lead_cmp;
    bus_req_t ibus_trail_cmp;
    bus_req_t dbus_lead_cmp;
    bus_req_t dbus_trail_cmp;

    response_voter voter (
        .s_clk_i       (s_clk_i),
        .reset_i       (reset_i),
        .i_hready_i    (i_hready_i),
        .i_hresp_i     (i_hresp_i),
        .i_hrdata_i    (i_hrdata_i),
        .d_hready_i    (d_hready_i),
        .d_hresp_i     (d_hresp_i),
        .d_hrdata_i    (d_hrdata_i),
        .meip_i        (meip_i),
        .mtip_i        (mtip_i),
        .lead_irsp_o   (lead_irsp_o),
        .lead_drsp_o   (lead_drsp_o),
        .trail_irsp_o  (trail_irsp_o),
        .trail_drsp_o  (trail_drsp_o),
        .trail_meip_o  (trail_meip_o),
        .trail_mtip_o  (trail_mtip_o),
        .trail_reset_o (trail_reset_o)
    );

    request_align ibus_align (
        .s_clk_i     (s_clk_i),
        .reset_i     (reset_i),
        .lead_req_i  (lead_ireq_i),
        .trail_req_i (trail_ireq_i),
        .lead_cmp_o  (ibus_lead_cmp),
        .trail_cmp_o (ibus_trail_cmp)
    );

    request_align dbus_align (
        .s_clk_i     (s_clk_i),
        .reset_i     (reset_i),
        .lead_req_i  (lead_dreq_i),
        .trail_req_i (trail_dreq_i),
        .lead_cmp_o  (dbus_lead_cmp),
        .trail_cmp_o (dbus_trail_cmp)
    );

    lockstep_compare compare (
        .ibus_lead_i  (ibus_lead_cmp),
        .ibus_trail_i (ibus_trail_cmp),
        .ibus_live_i  (lead_ireq_i),    // Bus drive comes from the leading core
        .dbus_lead_i  (dbus_lead_cmp),
        .dbus_trail_i (dbus_trail_cmp),
        .dbus_live_i  (lead_dreq_i),
        .ibus_req_o   (ibus_req_o),
        .dbus_req_o   (dbus_req_o),
        .unrec_err_o  (unrec_err_o)
    );

endmodule

// ==== design/lockstep_compare.sv ====
// Output side of the lockstep supervisor.
// Compares the aligned leading and trailing requests of both buses and
// raises the unrecoverable error when they disagree. The external buses
// are driven by the leading core's live requests.

module lockstep_compare (
    input  dcls_pkg::bus_req_t ibus_lead_i,     // Aligned instruction bus pair
    input  dcls_pkg::bus_req_t ibus_trail_i,
    input  dcls_pkg::bus_req_t ibus_live_i,     // Leading core, undelayed
    input  dcls_pkg::bus_req_t dbus_lead_i,     // Aligned data bus pair
    input  dcls_pkg::bus_req_t dbus_trail_i,
    input  dcls_pkg::bus_req_t dbus_live_i,
    output dcls_pkg::bus_req_t ibus_req_o,
    output dcls_pkg::bus_req_t dbus_req_o,
    output logic               unrec_err_o
);

    import dcls_pkg::*;

    logic ibus_mismatch;
    logic dbus_mismatch;

    // Disagreement rule shared by both buses
    function automatic logic disagree(input bus_req_t a, input bus_req_t b);
        logic addr_phase_diff;
        logic data_phase_diff;
        addr_phase_diff = (a.haddr   != b.haddr)  ||
                          (a.hwrite  != b.hwrite) ||
                          (a.hsize   != b.hsize)  ||
                          (a.hparity != b.hparity);
        // Data phase belongs to the previous transfer, so htrans does not qualify it
        data_phase_diff = (a.hwdata != b.hwdata);
        if (a.htrans != b.htrans) begin
            return 1'b1;
        end
        if (a.htrans != HTRANS_IDLE && addr_phase_diff) begin
            return 1'b1;
        end
        return data_phase_diff;
    endfunction

    always_comb begin
        ibus_mismatch = disagree(ibus_lead_i, ibus_trail_i);
        dbus_mismatch = disagree(dbus_lead_i, dbus_trail_i);
    end

    assign unrec_err_o = ibus_mismatch | dbus_mismatch;

    // External buses follow the leading core with no added latency
    assign ibus_req_o = ibus_live_i;
    assign dbus_req_o = dbus_live_i;

endmodule

// ==== design/request_align.sv ====
// Request alignment for one bus.
// The leading request is delayed by CORE_LAG + 1 cycles and the trailing
// request by CORE_LAG cycles, so both copies of one program step leave
// this block in the same cycle. One instance serves each bus.

module request_align (
    input  logic               s_clk_i,
    input  logic               reset_i,
    input  dcls_pkg::bus_req_t lead_req_i,     // Live request of the leading core
    input  dcls_pkg::bus_req_t trail_req_i,    // Live request of the trailing core
    output dcls_pkg::bus_req_t lead_cmp_o,
    output dcls_pkg::bus_req_t trail_cmp_o
);

    import dcls_pkg::*;

    // Leading chain holds up to two requests in flight
    bus_req_t lead_pipe [0:CORE_LAG];
    bus_req_t trail_pipe [0:CORE_LAG-1];

    always_ff @(posedge s_clk_i) begin
        lead_pipe[0]  <= lead_req_i;
        trail_pipe[0] <= trail_req_i;
        for (int i = 1; i <= CORE_LAG; i++) begin
            lead_pipe[i] <= lead_pipe[i-1];
        end
        for (int i = 1; i < CORE_LAG; i++) begin
            trail_pipe[i] <= trail_pipe[i-1];
        end

        // Idle transfers and clear write data keep the comparator quiet
        if (reset_i) begin
            for (int i = 0; i <= CORE_LAG; i++) begin
                lead_pipe[i].htrans <= HTRANS_IDLE;
                lead_pipe[i].hwdata <= '0;
            end
            for (int i = 0; i < CORE_LAG; i++) begin
                trail_pipe[i].htrans <= HTRANS_IDLE;
                trail_pipe[i].hwdata <= '0;
            end
        end
    end

    assign lead_cmp_o  = lead_pipe[CORE_LAG];       // Issued two cycles ago
    assign trail_cmp_o = trail_pipe[CORE_LAG-1];    // Issued one cycle ago

endmodule

// ==== design/response_voter.sv ====
// Input side of the lockstep supervisor.
// Votes the triplicated hready and hresp flags of both buses, hands the
// leading core its response in the same cycle and delays the responses,
// interrupts and reset by one cycle for the trailing core.

module response_voter (
    input  logic              s_clk_i,
    input  logic              reset_i,

    // Instruction bus response
    input  dcls_pkg::triple_t i_hready_i,
    input  dcls_pkg::triple_t i_hresp_i,
    input  dcls_pkg::data_t   i_hrdata_i,

    // Data bus response
    input  dcls_pkg::triple_t d_hready_i,
    input  dcls_pkg::triple_t d_hresp_i,
    input  dcls_pkg::data_t   d_hrdata_i,

    input  logic              meip_i,       // External interrupt
    input  logic              mtip_i,       // Timer interrupt

    output dcls_pkg::bus_rsp_t lead_irsp_o,
    output dcls_pkg::bus_rsp_t lead_drsp_o,
    output dcls_pkg::bus_rsp_t trail_irsp_o,
    output dcls_pkg::bus_rsp_t trail_drsp_o,
    output logic               trail_meip_o,
    output logic               trail_mtip_o,
    output logic               trail_reset_o
);

    import dcls_pkg::*;

    // 2-of-3 majority of one redundant flag
    function automatic logic vote(input triple_t t);
        return (t[0] & t[1]) | (t[0] & t[2]) | (t[1] & t[2]);
    endfunction

    // Leading core sees the voted response without delay
    always_comb begin
        lead_irsp_o.hready = vote(i_hready_i);
        lead_irsp_o.hresp  = vote(i_hresp_i);
        lead_irsp_o.hrdata = i_hrdata_i;

        lead_drsp_o.hready = vote(d_hready_i);
        lead_drsp_o.hresp  = vote(d_hresp_i);
        lead_drsp_o.hrdata = d_hrdata_i;
    end

    // Trailing core gets the same values one cycle later,
    // which keeps it exactly CORE_LAG steps behind
    always_ff @(posedge s_clk_i) begin
        trail_irsp_o <= lead_irsp_o;
        trail_drsp_o <= lead_drsp_o;
        trail_meip_o <= meip_i;
        trail_mtip_o <= mtip_i;
    end

    // Trailing reset releases one cycle after reset_i
    always_ff @(posedge s_clk_i) begin
        trail_reset_o <= reset_i;
    end

endmodule

// ==== sim/tb_dcls_util.svh ====
// Helpers shared by the lockstep testbench.
// Holds the LFSR random source, the value check and the error counters.
// Included inside the testbench module body.

`ifndef TB_DCLS_UTIL_SVH
`define TB_DCLS_UTIL_SVH

int check_count = 0;
int error_count = 0;

logic [31:0] lfsr_state = 32'd89935;    // Fixed seed

// One right shift of a 32-bit Galois LFSR, polynomial x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// Collect count random bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
endfunction

// Compare one observed value with its expected value
task automatic check_value(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
    end
endtask

`endif

// ==== sim/tb_dcls.sv ====
// Testbench for the dual-core lockstep supervisor.
// Stands in for both cores with random leading requests, a trailing core
// that replays them one cycle later and occasional corrupted trailing fields.
// A model of the two-cycle alignment predicts the error flag, and the
// voted and delayed responses are checked every cycle.

module tb_dcls;

    import dcls_pkg::*;

    `include "tb_dcls_util.svh"

    localparam int CLEAN_CYCLES  = 500;
    localparam int FAULT_CYCLES  = 800;
    localparam int RESET_TIMEOUT = 8;

    // Field that a fault corrupts
    localparam int FIELD_HADDR   = 1;
    localparam int FIELD_HSIZE   = 2;
    localparam int FIELD_HWRITE  = 3;
    localparam int FIELD_HPARITY = 4;
    localparam int FIELD_HTRANS  = 5;
    localparam int FIELD_HWDATA  = 6;

    logic     s_clk_i;
    logic     reset_i;
    triple_t  i_hready_i;
    triple_t  i_hresp_i;
    data_t    i_hrdata_i;
    triple_t  d_hready_i;
    triple_t  d_hresp_i;
    data_t    d_hrdata_i;
    logic     meip_i;
    logic     mtip_i;
    bus_req_t lead_ireq_i;
    bus_req_t trail_ireq_i;
    bus_req_t lead_dreq_i;
    bus_req_t trail_dreq_i;
    bus_rsp_t lead_irsp_o;
    bus_rsp_t lead_drsp_o;
    bus_rsp_t trail_irsp_o;
    bus_rsp_t trail_drsp_o;
    logic     trail_meip_o;
    logic     trail_mtip_o;
    logic     trail_reset_o;
    bus_req_t ibus_req_o;
    bus_req_t dbus_req_o;
    logic     unrec_err_o;

    // Model state
    bus_req_t ilead_q[$];       // Leading requests of the last two cycles
    bus_req_t itrail_q[$];      // Trailing request of the last cycle
    bus_req_t dlead_q[$];
    bus_req_t dtrail_q[$];
    bus_rsp_t exp_irsp;
    bus_rsp_t exp_drsp;
    bus_rsp_t prev_irsp;
    bus_rsp_t prev_drsp;
    logic     prev_meip;
    logic     prev_mtip;
    int       masked_faults = 0;
    int       raised_faults = 0;

    dcls_top dcls_top_inst (.*);

    initial begin
        s_clk_i = 1'b0;
        forever #20 s_clk_i = ~s_clk_i;
    end

    function automatic bus_req_t random_request();
        bus_req_t req;
        req.htrans  = htrans_t'(rand_bits(2));    // Idle about one time in four
        req.haddr   = rand_bits(32);
        req.hwrite  = 1'(rand_bits(1));
        req.hsize   = hsize_t'(rand_bits(3));
        req.hparity = parity_t'(rand_bits(6));
        req.hwdata  = rand_bits(32);
        return req;
    endfunction

    // Three copies of one flag with at most one of them flipped
    function automatic triple_t redundant_copies(input logic value, input logic [1:0] flip);
        triple_t t;
        t = {3{value}};
        if (flip != 2'd3) begin
            t[flip] = ~value;
        end
        return t;
    endfunction

    // Expected comparator verdict for one aligned pair
    function automatic logic requests_mismatch(input bus_req_t lead, input bus_req_t trail);
        if (lead.htrans != trail.htrans || lead.hwdata != trail.hwdata) begin
            return 1'b1;
        end
        if (lead.htrans == HTRANS_IDLE) begin
            return 1'b0;    // Address phase ignored on idle transfers
        end
        return {lead.haddr, lead.hwrite, lead.hsize, lead.hparity} !=
               {trail.haddr, trail.hwrite, trail.hsize, trail.hparity};
    endfunction

    task automatic corrupt_field(inout bus_req_t req, input int field);
        case (field)
            FIELD_HADDR:   req.haddr   ^= 32'd1 << rand_bits(5);
            FIELD_HSIZE:   req.hsize   ^= 3'd1 << (rand_bits(2) % 3);
            FIELD_HWRITE:  req.hwrite  = ~req.hwrite;
            FIELD_HPARITY: req.hparity ^= 6'd1 << (rand_bits(3) % 6);
            FIELD_HTRANS:  req.htrans  ^= htrans_t'(1 + rand_bits(2) % 3);
            FIELD_HWDATA:  req.hwdata  ^= 32'd1 << rand_bits(5);
            default: ;
        endcase
    endtask

    // Random response of one bus and the value the vote must give
    task automatic drive_response(output triple_t rdy, output triple_t rsp,
                                  output data_t rdata, output bus_rsp_t voted);
        logic ready_bit;
        logic resp_bit;
        ready_bit = 1'(rand_bits(1));
        resp_bit  = 1'(rand_bits(1));
        rdy   = redundant_copies(ready_bit, 2'(rand_bits(2)));
        rsp   = redundant_copies(resp_bit, 2'(rand_bits(2)));
        rdata = rand_bits(32);
        voted.hready = ready_bit;
        voted.hresp  = resp_bit;
        voted.hrdata = rdata;
    endtask

    // Drives one clock cycle on the falling edge and checks it shortly after
    task automatic run_cycle(input logic inject);
        int   field;
        logic on_dbus;
        logic exp_err;
        @(negedge s_clk_i);
        trail_ireq_i = lead_ireq_i;     // Trailing core replays the last step
        trail_dreq_i = lead_dreq_i;
        lead_ireq_i  = random_request();
        lead_dreq_i  = random_request();
        if (inject && rand_bits(3) == 0) begin
            field   = 1 + int'(rand_bits(3) % 6);
            on_dbus = 1'(rand_bits(1));
            if (on_dbus) begin
                corrupt_field(trail_dreq_i, field);
            end else begin
                corrupt_field(trail_ireq_i, field);
            end
            if (field <= FIELD_HPARITY) begin
                if ((on_dbus ? trail_dreq_i.htrans : trail_ireq_i.htrans) == HTRANS_IDLE) begin
                    masked_faults++;
                end else begin
                    raised_faults++;
                end
            end
        end
        drive_response(i_hready_i, i_hresp_i, i_hrdata_i, exp_irsp);
        drive_response(d_hready_i, d_hresp_i, d_hrdata_i, exp_drsp);
        meip_i = 1'(rand_bits(1));
        mtip_i = 1'(rand_bits(1));
        #1;

        check_value("lead_irsp_o", 128'(lead_irsp_o), 128'(exp_irsp));
        check_value("lead_drsp_o", 128'(lead_drsp_o), 128'(exp_drsp));
        check_value("trail_irsp_o", 128'(trail_irsp_o), 128'(prev_irsp));
        check_value("trail_drsp_o", 128'(trail_drsp_o), 128'(prev_drsp));
        check_value("trail_meip_o", 128'(trail_meip_o), 128'(prev_meip));
        check_value("trail_mtip_o", 128'(trail_mtip_o), 128'(prev_mtip));
        check_value("ibus_req_o", 128'(ibus_req_o), 128'(lead_ireq_i));
        check_value("dbus_req_o", 128'(dbus_req_o), 128'(lead_dreq_i));

        // Leading step from two cycles ago against the trailing one from last cycle
        exp_err = requests_mismatch(ilead_q[0], itrail_q[0]) |
                  requests_mismatch(dlead_q[0], dtrail_q[0]);
        check_value("unrec_err_o", 128'(unrec_err_o), 128'(exp_err));

        ilead_q.push_back(lead_ireq_i);
        dlead_q.push_back(lead_dreq_i);
        itrail_q.push_back(trail_ireq_i);
        dtrail_q.push_back(trail_dreq_i);
        void'(ilead_q.pop_front());
        void'(dlead_q.pop_front());
        void'(itrail_q.pop_front());
        void'(dtrail_q.pop_front());
        prev_irsp = exp_irsp;
        prev_drsp = exp_drsp;
        prev_meip = meip_i;
        prev_mtip = mtip_i;
    endtask

    initial begin
        int waited;
        reset_i      = 1'b1;
        i_hready_i   = '0;
        i_hresp_i    = '0;
        i_hrdata_i   = '0;
        d_hready_i   = '0;
        d_hresp_i    = '0;
        d_hrdata_i   = '0;
        meip_i       = 1'b0;
        mtip_i       = 1'b0;
        lead_ireq_i  = '0;
        trail_ireq_i = '0;
        lead_dreq_i  = '0;
        trail_dreq_i = '0;
        prev_irsp    = '0;
        prev_drsp    = '0;
        prev_meip    = 1'b0;
        prev_mtip    = 1'b0;
        for (int i = 0; i < 2; i++) begin
            ilead_q.push_back('0);
            dlead_q.push_back('0);
        end
        itrail_q.push_back('0);
        dtrail_q.push_back('0);

        // Unrelated lead and trail requests while reset is held
        repeat (3) begin
            @(negedge s_clk_i);
            lead_ireq_i  = random_request();
            trail_ireq_i = random_request();
            lead_dreq_i  = random_request();
            trail_dreq_i = random_request();
        end
        @(negedge s_clk_i);
        reset_i      = 1'b0;
        lead_ireq_i  = '0;
        trail_ireq_i = '0;
        lead_dreq_i  = '0;
        trail_dreq_i = '0;
        #1;
        check_value("trail_reset_o", 128'(trail_reset_o), 128'(1));
        check_value("unrec_err_o", 128'(unrec_err_o), '0);

        waited = 0;
        while (trail_reset_o === 1'b1 && waited < RESET_TIMEOUT) begin
            run_cycle(1'b0);
            waited++;
        end

        if (trail_reset_o !== 1'b0) begin
            $display("trail_reset_o still high %0d cycles after reset_i fell", waited);
            $display("tests failed");
            $finish;
        end else begin
            check_value("trail_reset_o delay", 128'(waited), 128'(1));
            repeat (CLEAN_CYCLES) run_cycle(1'b0);
            repeat (FAULT_CYCLES) run_cycle(1'b1);
            if (masked_faults == 0 || raised_faults == 0) begin
                $display("Address faults not covered: %0d on idle and %0d on active transfers",
                         masked_faults, raised_faults);
                error_count++;
            end
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+sim
design/dcls_pkg.sv
design/response_voter.sv
design/request_align.sv
design/lockstep_compare.sv
design/dcls_top.sv
sim/tb_dcls.sv
